// ==== common/board_pkg.sv ====
// Board platform package: word type, RNG lane constants, clock and reset defaults, GPIO bits.
`default_nettype none

package board_pkg;

    typedef logic [31:0] word_t;

    // Random source.
    localparam int NUM_LANES = 4;
    localparam word_t LFSR_TAPS = 32'h8020_0003;
    localparam word_t SEED_BASE = 32'h1ace_b00c;
    localparam word_t SEED_STEP = 32'h9e37_79b9;

    // Reset stretch in clk cycles.
    localparam int RST_LEN_DEF = 3;

    // Board clock and RTC tick rate.
    localparam int CLK_HZ_DEF = 12_000_000;
    localparam int RTC_HZ_DEF = 1_000_000;

    // GPIO bit map.
    localparam int LED_R_BIT = 8;
    localparam int LED_G_BIT = 9;
    localparam int LED_B_BIT = 10;
    localparam int BTN_GPIO_BIT = 11;

endpackage

`default_nettype wire

// ==== common/rng_lane_if.sv ====
// Lane bus between the RNG seeder, one LFSR lane and the combiner.
`default_nettype none

interface rng_lane_if;
    import board_pkg::*;

    logic load;
    word_t seed;
    logic step;
    word_t state;

    modport seeder (
        output load,
        output seed
    );

    modport lane (
        input load,
        input seed,
        input step,
        output state
    );

    // Load is visible here so the combiner can blank the output word.
    modport combiner (
        input load,
        input state,
        output step
    );

endinterface

`default_nettype wire

// ==== src/io_pads.sv ====
// Pad registers for UART and buttons, GPIO to LED and button to GPIO mapping.
`default_nettype none

module io_pads (
    input logic clk,
    input logic tx_core,
    input logic rx,
    input logic [1:0] btn,
    input board_pkg::word_t gpio_out,
    output logic tx,
    output logic rx_core,
    output logic [1:0] btn_sync,
    output board_pkg::word_t gpio_in,
    output logic led_r,
    output logic led_g,
    output logic led_b
);
    import board_pkg::*;

    // One register stage on every pad.
    always_ff @(posedge clk) begin
        tx <= tx_core;
        rx_core <= rx;
        btn_sync <= btn;
    end

    // LEDs are active low on the board.
    assign led_r = ~gpio_out[LED_R_BIT];
    assign led_g = ~gpio_out[LED_G_BIT];
    assign led_b = ~gpio_out[LED_B_BIT];

    always_comb begin
        gpio_in = gpio_out;
        gpio_in[BTN_GPIO_BIT] = btn_sync[1];
    end

endmodule

`default_nettype wire

// ==== src/power_ctrl.sv ====
// Stretched system reset counter and sticky shutdown flag.
`default_nettype none

module power_ctrl #(
    parameter int RST_LEN = board_pkg::RST_LEN_DEF
) (
    input logic clk,
    input logic rst,
    input logic pmu_rst,
    input logic pmu_shdn,
    input logic btn_rst,
    output logic sys_rst,
    output logic shdn
);

    localparam int CNT_W = $clog2(RST_LEN + 1);

    logic [CNT_W-1:0] cnt;
    logic rst_req;

    assign rst_req = rst | pmu_rst | btn_rst;

    always_ff @(posedge clk) begin
        if (rst_req) begin
            // Any reset source restarts the stretch and wakes the board.
            cnt <= CNT_W'(RST_LEN);
            shdn <= 1'b0;
        end else begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            if (pmu_shdn) begin
                shdn <= 1'b1;
            end
        end
    end

    assign sys_rst = (cnt != '0);

endmodule

`default_nettype wire

// ==== src/rtc_tick.sv ====
// Clock divider giving a single-cycle RTC tick.
`default_nettype none

module rtc_tick #(
    parameter int CLK_HZ = board_pkg::CLK_HZ_DEF,
    parameter int RTC_HZ = board_pkg::RTC_HZ_DEF
) (
    input logic clk,
    input logic rst,
    input logic hold,
    output logic tick
);

    localparam int DIV = CLK_HZ / RTC_HZ;
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            tick <= 1'b0;
        end else if (hold) begin
            // Frozen in shutdown.
            tick <= 1'b0;
        end else if (cnt == CNT_W'(DIV - 1)) begin
            cnt <= '0;
            tick <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rng/rng_seeder.sv ====
// RNG seeder: per-lane seeds and load pulses after reset and on reseed.
`default_nettype none

module rng_seeder #(
    parameter int NUM_LANES = board_pkg::NUM_LANES
) (
    input logic clk,
    input logic rst,
    input logic reseed,
    rng_lane_if.seeder lanes [NUM_LANES]
);
    import board_pkg::*;

    word_t gen;
    logic armed;
    logic reseed_q;
    logic load;

    always_ff @(posedge clk) begin
        if (rst) begin
            gen <= '0;
            armed <= 1'b1;
            reseed_q <= 1'b0;
        end else begin
            armed <= 1'b0;
            reseed_q <= reseed;
            if (reseed) begin
                gen <= gen + 1'b1;
            end
        end
    end

    // Armed covers the first cycle out of reset.
    assign load = armed | reseed_q;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign lanes[i].load = load;
        assign lanes[i].seed = (SEED_BASE + SEED_STEP * word_t'(i)) ^ gen;
    end

endmodule

`default_nettype wire

// ==== rng/lfsr_lane.sv ====
// One 32-bit Galois LFSR lane stepping on request.
`default_nettype none

module lfsr_lane (
    input logic clk,
    input logic rst,
    rng_lane_if.lane lane
);
    import board_pkg::*;

    word_t state;
    word_t seed_safe;
    word_t next;

    // All-zero is the lock-up state of the LFSR.
    assign seed_safe = (lane.seed == '0) ? SEED_BASE : lane.seed;

    always_comb begin
        next = {1'b0, state[31:1]};
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEED_BASE;
        end else if (lane.load) begin
            state <= seed_safe;
        end else if (lane.step) begin
            state <= next;
        end
    end

    assign lane.state = state;

endmodule

`default_nettype wire

// ==== rng/rng_combiner.sv ====
// RNG combiner: XOR of lane states handed out over valid/ready.
`default_nettype none

module rng_combiner #(
    parameter int NUM_LANES = board_pkg::NUM_LANES
) (
    input logic clk,
    input logic rst,
    input logic hold,
    rng_lane_if.combiner lanes [NUM_LANES],
    output board_pkg::word_t rand_data,
    input logic rand_ready,
    output logic rand_valid
);
    import board_pkg::*;

    word_t states [NUM_LANES];
    logic load_seen;
    logic fire;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign states[i] = lanes[i].state;
        assign lanes[i].step = fire;
    end

    // All lanes share one load strobe.
    assign load_seen = lanes[0].load;

    always_comb begin
        rand_data = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            rand_data = rand_data ^ states[i];
        end
    end

    // No word is offered in reset, in a load cycle or in shutdown.
    assign rand_valid = ~rst & ~load_seen & ~hold;

    // Lanes only advance on an accepted word.
    assign fire = rand_valid & rand_ready;

endmodule

`default_nettype wire

// ==== src/board_platform.sv ====
// Board platform top: pads, power control, RTC tick and hardware random source.
`default_nettype none

module board_platform #(
    parameter int RST_LEN = board_pkg::RST_LEN_DEF,
    parameter int CLK_HZ = board_pkg::CLK_HZ_DEF,
    parameter int RTC_HZ = board_pkg::RTC_HZ_DEF,
    parameter int NUM_LANES = board_pkg::NUM_LANES
) (
    input logic clk,
    input logic rst,
    input logic tx_core,
    output logic rx_core,
    input board_pkg::word_t gpio_out,
    output board_pkg::word_t gpio_in,
    output logic tx,
    input logic rx,
    input logic [1:0] btn,
    output logic led_r,
    output logic led_g,
    output logic led_b,
    input logic pmu_rst,
    input logic pmu_shdn,
    output logic sys_rst,
    output logic shdn,
    output logic rtc_tick,
    output board_pkg::word_t rand_data,
    output logic rand_valid,
    input logic rand_ready,
    input logic reseed
);

    logic [1:0] btn_sync;
    logic blk_rst;

    rng_lane_if lane_bus [NUM_LANES] ();

    // Tick and RNG stay in reset until the stretched reset ends.
    assign blk_rst = rst | sys_rst;

    io_pads io_pads_inst (
        .clk(clk),
        .tx_core(tx_core),
        .rx(rx),
        .btn(btn),
        .gpio_out(gpio_out),
        .tx(tx),
        .rx_core(rx_core),
        .btn_sync(btn_sync),
        .gpio_in(gpio_in),
        .led_r(led_r),
        .led_g(led_g),
        .led_b(led_b)
    );

    power_ctrl #(.RST_LEN(RST_LEN)) power_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .pmu_rst(pmu_rst),
        .pmu_shdn(pmu_shdn),
        .btn_rst(btn_sync[0]),
        .sys_rst(sys_rst),
        .shdn(shdn)
    );

    rtc_tick #(.CLK_HZ(CLK_HZ), .RTC_HZ(RTC_HZ)) rtc_tick_inst (
        .clk(clk),
        .rst(blk_rst),
        .hold(shdn),
        .tick(rtc_tick)
    );

    rng_seeder #(.NUM_LANES(NUM_LANES)) rng_seeder_inst (
        .clk(clk),
        .rst(blk_rst),
        .reseed(reseed),
        .lanes(lane_bus)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lfsr_lane lfsr_lane_inst (
            .clk(clk),
            .rst(blk_rst),
            .lane(lane_bus[i])
        );
    end

    rng_combiner #(.NUM_LANES(NUM_LANES)) rng_combiner_inst (
        .clk(clk),
        .rst(blk_rst),
        .hold(shdn),
        .lanes(lane_bus),
        .rand_data(rand_data),
        .rand_ready(rand_ready),
        .rand_valid(rand_valid)
    );

endmodule

`default_nettype wire

// ==== test/board_platform_assert.sv ====
// Concurrent valid/ready assertions on the RNG combiner output, bound into rng_combiner.
`default_nettype none

module board_platform_assert (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic load_seen,
    input logic rand_valid,
    input logic rand_ready,
    input board_pkg::word_t rand_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // A waiting word keeps its value; only reset, shutdown or a load may drop valid.
    held_word: assert property (@(posedge clk)
        rand_valid && !rand_ready && !rst
        |=> $stable(rand_data) && (rand_valid || rst || hold || load_seen))
    else begin
        $error("random word not held while waiting for ready");
        fail_count++;
    end

    // No word is offered while the block is in reset.
    reset_blank: assert property (@(posedge clk) rst |-> !rand_valid)
    else begin
        $error("random word valid during reset");
        fail_count++;
    end

    load_blank: assert property (@(posedge clk) load_seen |-> !rand_valid)
    else begin
        $error("random word valid during a seed load");
        fail_count++;
    end

endmodule

bind rng_combiner board_platform_assert board_platform_assert_inst (
    .clk(clk),
    .rst(rst),
    .hold(hold),
    .load_seen(load_seen),
    .rand_valid(rand_valid),
    .rand_ready(rand_ready),
    .rand_data(rand_data)
);

`default_nettype wire

// ==== test/tb_board_platform.sv ====
// Testbench for the board platform: random stimulus, reference model, checks and timeout.
`default_nettype none

module tb_board_platform;
    timeunit 1ns;
    timeprecision 1ps;

    import board_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES = 3000;
    // Reset plus run, with about a third in reserve.
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DRIVE_DELAY = 2;
    localparam int RTC_DIV = CLK_HZ_DEF / RTC_HZ_DEF;
    localparam logic [31:0] RNG_SEED = 32'h604c;

    logic clk;
    logic rst;
    logic tx_core;
    logic rx_core;
    word_t gpio_out;
    word_t gpio_in;
    logic tx;
    logic rx;
    logic [1:0] btn;
    logic led_r;
    logic led_g;
    logic led_b;
    logic pmu_rst;
    logic pmu_shdn;
    logic sys_rst;
    logic shdn;
    logic rtc_tick;
    word_t rand_data;
    logic rand_valid;
    logic rand_ready;
    logic reseed;

    // Reference model state, as seen after the coming clock edge.
    logic tx_m;
    logic rx_m;
    logic [1:0] btn_m;
    int rst_cnt_m;
    logic shdn_m;
    int rtc_cnt_m;
    logic tick_m;
    word_t gen_m;
    logic seed_due_m;
    logic reseed_m;
    word_t lane_m [NUM_LANES];

    int n_words;
    int n_reseeds;
    int n_ticks;
    int n_shdn;
    int n_resets;
    int cycles = 0;

    board_platform #(
        .RST_LEN(RST_LEN_DEF),
        .CLK_HZ(CLK_HZ_DEF),
        .RTC_HZ(RTC_HZ_DEF),
        .NUM_LANES(NUM_LANES)
    ) board_platform_inst (
        .clk(clk),
        .rst(rst),
        .tx_core(tx_core),
        .rx_core(rx_core),
        .gpio_out(gpio_out),
        .gpio_in(gpio_in),
        .tx(tx),
        .rx(rx),
        .btn(btn),
        .led_r(led_r),
        .led_g(led_g),
        .led_b(led_b),
        .pmu_rst(pmu_rst),
        .pmu_shdn(pmu_shdn),
        .sys_rst(sys_rst),
        .shdn(shdn),
        .rtc_tick(rtc_tick),
        .rand_data(rand_data),
        .rand_valid(rand_valid),
        .rand_ready(rand_ready),
        .reseed(reseed)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic compare_bit(string what, logic got, logic exp);
        assert (got === exp)
        else stop_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic compare_word(string what, word_t got, word_t exp);
        assert (got === exp)
        else stop_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // One Galois step: shift right, fold the taps in when bit 0 falls out.
    function automatic word_t lfsr_next(word_t s);
        word_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic word_t lane_seed(int i, word_t gen);
        word_t s;
        s = (SEED_BASE + SEED_STEP * word_t'(i)) ^ gen;
        if (s == '0) begin
            s = SEED_BASE;
        end
        return s;
    endfunction

    // Valid is low while the stretched reset runs, in a load cycle and in shutdown.
    function automatic logic model_valid();
        return !rst && rst_cnt_m == 0 && !seed_due_m && !reseed_m && !shdn_m;
    endfunction

    task automatic drive_inputs();
        word_t r;
        r = $urandom();
        tx_core = r[0];
        rx = r[1];
        btn[1] = r[2];
        rand_ready = r[3];
        gpio_out = $urandom();
        btn[0] = ($urandom() % 150) == 0;
        pmu_rst = ($urandom() % 100) == 0;
        pmu_shdn = ($urandom() % 120) == 0;
        reseed = ($urandom() % 30) == 0;
    endtask

    task automatic verify_outputs();
        word_t exp_gpio;
        word_t exp_word;
        exp_gpio = gpio_out;
        exp_gpio[BTN_GPIO_BIT] = btn_m[1];
        exp_word = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            exp_word = exp_word ^ lane_m[i];
        end
        compare_bit("tx", tx, tx_m);
        compare_bit("rx_core", rx_core, rx_m);
        compare_bit("led_r", led_r, ~gpio_out[LED_R_BIT]);
        compare_bit("led_g", led_g, ~gpio_out[LED_G_BIT]);
        compare_bit("led_b", led_b, ~gpio_out[LED_B_BIT]);
        compare_word("gpio_in", gpio_in, exp_gpio);
        compare_bit("sys_rst", sys_rst, rst_cnt_m != 0);
        compare_bit("shdn", shdn, shdn_m);
        compare_bit("rtc_tick", rtc_tick, tick_m);
        compare_bit("rand_valid", rand_valid, model_valid());
        if (model_valid()) begin
            compare_word("rand_data", rand_data, exp_word);
        end
    endtask

    // Moves the model across the coming clock edge with the inputs now applied.
    task automatic advance_model();
        logic blk_rst;
        logic load;
        logic fire;
        blk_rst = rst || (rst_cnt_m != 0);
        load = seed_due_m || reseed_m;
        fire = model_valid() && rand_ready;
        if (!rst) begin
            n_words += int'(fire);
            n_reseeds += int'(load && !blk_rst && gen_m != '0);
            n_ticks += int'(tick_m);
            n_shdn += int'(shdn_m);
            n_resets += int'(pmu_rst || btn_m[0]);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (blk_rst) begin
                lane_m[i] = SEED_BASE;
            end else if (load) begin
                lane_m[i] = lane_seed(i, gen_m);
            end else if (fire) begin
                lane_m[i] = lfsr_next(lane_m[i]);
            end
        end
        if (blk_rst) begin
            gen_m = '0;
            seed_due_m = 1'b1;
            reseed_m = 1'b0;
        end else begin
            seed_due_m = 1'b0;
            reseed_m = reseed;
            if (reseed) begin
                gen_m = gen_m + 32'd1;
            end
        end
        if (blk_rst) begin
            rtc_cnt_m = 0;
            tick_m = 1'b0;
        end else if (shdn_m) begin
            tick_m = 1'b0;
        end else begin
            tick_m = (rtc_cnt_m == RTC_DIV - 1);
            rtc_cnt_m = (rtc_cnt_m == RTC_DIV - 1) ? 0 : rtc_cnt_m + 1;
        end
        // Button reset comes from the registered pad.
        if (rst || pmu_rst || btn_m[0]) begin
            rst_cnt_m = RST_LEN_DEF;
            shdn_m = 1'b0;
        end else begin
            if (rst_cnt_m > 0) begin
                rst_cnt_m--;
            end
            if (pmu_shdn) begin
                shdn_m = 1'b1;
            end
        end
        tx_m = tx_core;
        rx_m = rx;
        btn_m = btn;
    endtask

    initial begin
        void'($urandom(RNG_SEED));
        rst = 1'b1;
        tx_core = 1'b0;
        rx = 1'b0;
        btn = '0;
        gpio_out = '0;
        pmu_rst = 1'b0;
        pmu_shdn = 1'b0;
        rand_ready = 1'b0;
        reseed = 1'b0;
        advance_model();
        for (int c = 0; c < RESET_CYCLES + RUN_CYCLES; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (c == RESET_CYCLES - 1) begin
                rst = 1'b0;
            end
            drive_inputs();
            @(negedge clk);
            if (board_platform_inst.rng_combiner_inst.board_platform_assert_inst.fail_count != 0) begin
                stop_run("A protocol assertion on the random source failed");
            end
            if (!rst) begin
                verify_outputs();
            end
            advance_model();
        end
        assert (n_words > 300) else stop_run("Too few random words were transferred");
        assert (n_reseeds > 20) else stop_run("Too few reseeds reached the lanes");
        assert (n_ticks > 20) else stop_run("Too few RTC ticks were seen");
        assert (n_shdn > 100) else stop_run("Shutdown was hardly ever active");
        assert (n_resets > 10) else stop_run("Too few reset requests were made");
        if (board_platform_inst.rng_combiner_inst.board_platform_assert_inst.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_run("A protocol assertion on the random source failed");
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/board_pkg.sv
common/rng_lane_if.sv
src/io_pads.sv
src/power_ctrl.sv
src/rtc_tick.sv
rng/rng_seeder.sv
rng/lfsr_lane.sv
rng/rng_combiner.sv
src/board_platform.sv
test/board_platform_assert.sv
test/tb_board_platform.sv

// ==== Makefile ====
TOP := tb_board_platform

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f flist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
